// File: rv32i_mem_subsys.f
+incdir+include
src/rv32i_types_pkg.sv
src/ex_mem_reg.sv
src/mem_stage.sv
src/data_ram.sv
src/mem_wb_align.sv
src/rv32i_mem_subsys.sv
verif/rv32i_mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run fails the script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module rv32i_mem_subsys_tb \
    -f rv32i_mem_subsys.f \
    -o rv32i_mem_subsys_sim

./obj_dir/rv32i_mem_subsys_sim

// File: verif/rv32i_mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_mem_cfg.svh"

module rv32i_mem_subsys_tb;
    import rv32i_types_pkg::*;

    localparam int num_instr     = 2000;
    localparam int reset_cycles  = 10;
    localparam int reset_timeout = 50;

    // The 64-byte window sits at the top of the data RAM.
    localparam rv32i_word win_base = rv32i_word'((4 << `RV32I_DMEM_AW) - 64);

    typedef struct packed {
        logic      valid;
        logic      we;
        rv32i_reg  rd;
        logic      chk_data;
        rv32i_word data;
    } wb_exp_t;

    typedef struct packed {
        logic      redirect;
        rv32i_word target;
    } br_exp_t;

    logic       clk_i;
    logic       arst_n_i;
    logic       ex_valid_i;
    ex_result_t ex_result_i;
    logic       pc_redirect_o;
    rv32i_word  pc_target_o;
    logic       wb_valid_o;
    logic       wb_we_o;
    rv32i_reg   wb_rd_o;
    rv32i_word  wb_data_o;

    logic [7:0]  model_mem [64];
    logic        model_written [64];  // a load is only checked on bytes stored before.
    wb_exp_t     wb_queue [$];
    br_exp_t     br_queue [$];
    logic [31:0] lfsr_state;

    rv32i_mem_subsys dut_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ex_valid_i    (ex_valid_i),
        .ex_result_i   (ex_result_i),
        .pc_redirect_o (pc_redirect_o),
        .pc_target_o   (pc_target_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    initial begin
        arst_n_i = 1'b0;
        repeat (reset_cycles) @(posedge clk_i);
        arst_n_i <= 1'b1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;  // taps of x^32 + x^22 + x^2 + x + 1.
        end
        return next;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            value[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                  input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic model_store(input rv32i_funct3 f3, input logic [5:0] off,
                               input rv32i_word data);
        logic [5:0] o1;
        logic [5:0] o2;
        logic [5:0] o3;
        o1 = off + 6'd1;
        o2 = off + 6'd2;
        o3 = off + 6'd3;
        model_mem[off] = data[7:0];
        model_written[off] = 1'b1;
        if (f3 != f3_byte) begin
            model_mem[o1] = data[15:8];
            model_written[o1] = 1'b1;
        end
        if (f3 == f3_word) begin
            model_mem[o2] = data[23:16];
            model_mem[o3] = data[31:24];
            model_written[o2] = 1'b1;
            model_written[o3] = 1'b1;
        end
    endtask

    task automatic model_load(input rv32i_funct3 f3, input logic [5:0] off,
                              output rv32i_word value, output logic known);
        logic [5:0]  o1;
        logic [5:0]  o2;
        logic [5:0]  o3;
        logic [31:0] raw;
        o1 = off + 6'd1;
        o2 = off + 6'd2;
        o3 = off + 6'd3;
        raw = {model_mem[o3], model_mem[o2], model_mem[o1], model_mem[off]};
        case (f3)
            f3_byte:   value = {{24{raw[7]}}, raw[7:0]};
            f3_half:   value = {{16{raw[15]}}, raw[15:0]};
            f3_byte_u: value = {24'd0, raw[7:0]};
            f3_half_u: value = {16'd0, raw[15:0]};
            default:   value = raw;
        endcase
        known = model_written[off];
        if (f3[1:0] != 2'b00) begin
            known = known & model_written[o1];  // halfword and word.
        end
        if (f3 == f3_word) begin
            known = known & model_written[o2] & model_written[o3];
        end
    endtask

    task automatic build_instr(output logic valid, output ex_result_t res,
                               output wb_exp_t wexp, output br_exp_t bexp);
        logic [31:0] r;
        logic [31:0] kind;
        logic [5:0]  off;
        rv32i_word   ld_val;
        logic        ld_known;

        take_bits(3, r);
        valid = |r[2:0];
        take_bits(32, r);
        res.pc = {r[31:2], 2'b00};
        res.pc_plus4 = res.pc + 32'd4;
        take_bits(32, r);
        res.alu_out = r;
        take_bits(32, r);
        res.rs2_out = r;
        take_bits(1, r);
        res.br_en = r[0];
        take_bits(5, r);
        res.rd = r[4:0];
        take_bits(1, r);
        res.ctrl.marmux_sel   = r[0];
        res.ctrl.funct3       = 3'b000;
        res.ctrl.load_regfile = 1'b0;
        res.ctrl.mem_read     = 1'b0;
        res.ctrl.mem_write    = 1'b0;
        res.ctrl.mem_byte_en  = 4'b0000;

        take_bits(4, kind);
        case (kind[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                res.ctrl.opcode = kind[0] ? op_reg : op_imm;
                take_bits(3, r);
                res.ctrl.funct3 = r[2:0];
                res.ctrl.load_regfile = 1'b1;
            end
            4'd4, 4'd5: begin
                res.ctrl.opcode = kind[0] ? op_jalr : op_jal;
                res.ctrl.load_regfile = 1'b1;
            end
            4'd6, 4'd7: begin
                res.ctrl.opcode = op_br;
                take_bits(3, r);
                res.ctrl.funct3 = r[2:0];
            end
            4'd8, 4'd9, 4'd10: begin
                res.ctrl.opcode = op_store;
                res.ctrl.funct3 = {1'b0, kind[1:0]};  // sb, sh, sw.
                res.ctrl.mem_write = 1'b1;
            end
            default: begin
                res.ctrl.opcode = op_load;
                res.ctrl.load_regfile = 1'b1;
                res.ctrl.mem_read = 1'b1;
                case (kind[3:0])
                    4'd11:   res.ctrl.funct3 = f3_byte;
                    4'd12:   res.ctrl.funct3 = f3_half;
                    4'd13:   res.ctrl.funct3 = f3_word;
                    4'd14:   res.ctrl.funct3 = f3_byte_u;
                    default: res.ctrl.funct3 = f3_half_u;
                endcase
            end
        endcase

        off = '0;
        if (kind[3:0] >= 4'd8) begin
            take_bits(6, r);
            off = r[5:0];
            res.ctrl.marmux_sel = 1'b1;
            case (res.ctrl.funct3[1:0])
                2'b00: res.ctrl.mem_byte_en = 4'b0001;
                2'b01: begin
                    res.ctrl.mem_byte_en = 4'b0011;
                    off[0] = 1'b0;  // halfwords stay naturally aligned.
                end
                default: begin
                    res.ctrl.mem_byte_en = 4'b1111;
                    off[1:0] = 2'b00;
                end
            endcase
            res.alu_out = win_base + {26'd0, off};
        end

        bexp.redirect = valid & (res.ctrl.opcode == op_br) & res.br_en;
        bexp.target   = res.alu_out;

        wexp.valid    = valid;
        wexp.we       = valid & res.ctrl.load_regfile & (res.rd != 5'd0);
        wexp.rd       = res.rd;
        wexp.chk_data = 1'b0;
        wexp.data     = '0;
        if (valid) begin
            if (kind[3:0] <= 4'd3) begin
                wexp.chk_data = 1'b1;
                wexp.data = res.alu_out;
            end else if (kind[3:0] <= 4'd5) begin
                wexp.chk_data = 1'b1;
                wexp.data = res.pc_plus4;
            end else if (res.ctrl.mem_write) begin
                model_store(res.ctrl.funct3, off, res.rs2_out);
            end else if (res.ctrl.mem_read) begin
                model_load(res.ctrl.funct3, off, ld_val, ld_known);
                wexp.chk_data = ld_known;
                wexp.data = ld_val;
            end
        end
    endtask

    initial begin
        int         wait_cycles;
        logic       valid;
        ex_result_t res;
        wb_exp_t    wexp;
        br_exp_t    bexp;
        wb_exp_t    wgot;
        br_exp_t    bgot;

        lfsr_state    = 32'd53;
        model_mem     = '{default: 8'h00};
        model_written = '{default: 1'b0};
        ex_valid_i    = 1'b0;
        ex_result_i   = '0;

        wait_cycles = 0;
        while (arst_n_i !== 1'b1) begin
            @(posedge clk_i);
            wait_cycles++;
            if (wait_cycles > reset_timeout) begin
                $display("ERROR: reset was not released within %0d cycles", reset_timeout);
                $display("Test failed");
                $fatal(1, "reset release timed out");
            end
        end

        @(negedge clk_i);
        compare_values(32'(wb_valid_o), 32'd0, "wb_valid_o after reset");
        compare_values(32'(wb_we_o), 32'd0, "wb_we_o after reset");
        compare_values(32'(pc_redirect_o), 32'd0, "pc_redirect_o after reset");

        // Two extra bubbles drain the last instructions out of the pipeline.
        for (int n = 0; n < num_instr + 2; n++) begin
            @(posedge clk_i);
            if (n < num_instr) begin
                build_instr(valid, res, wexp, bexp);
            end else begin
                valid = 1'b0;
                res   = '0;
                wexp  = '0;
                bexp  = '0;
            end
            ex_valid_i  <= valid;
            ex_result_i <= res;
            wb_queue.push_back(wexp);
            br_queue.push_back(bexp);

            @(negedge clk_i);
            if (br_queue.size() > 1) begin
                bgot = br_queue.pop_front();
                compare_values(32'(pc_redirect_o), 32'(bgot.redirect), "pc_redirect_o");
                if (bgot.redirect) begin
                    compare_values(pc_target_o, bgot.target, "pc_target_o");
                end
            end
            if (wb_queue.size() > 2) begin
                wgot = wb_queue.pop_front();
                compare_values(32'(wb_valid_o), 32'(wgot.valid), "wb_valid_o");
                compare_values(32'(wb_we_o), 32'(wgot.we), "wb_we_o");
                if (wgot.valid) begin
                    compare_values(32'(wb_rd_o), 32'(wgot.rd), "wb_rd_o");
                end
                if (wgot.chk_data) begin
                    compare_values(wb_data_o, wgot.data, "wb_data_o");
                end
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rv32i_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_mem_subsys (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         ex_valid_i,
    input  rv32i_types_pkg::ex_result_t  ex_result_i,
    output logic                         pc_redirect_o,
    output rv32i_types_pkg::rv32i_word   pc_target_o,
    output logic                         wb_valid_o,
    output logic                         wb_we_o,
    output rv32i_types_pkg::rv32i_reg    wb_rd_o,
    output rv32i_types_pkg::rv32i_word   wb_data_o
);
    import rv32i_types_pkg::*;

    logic       mem_valid;
    ex_result_t mem_result;
    mem_req_t   mem_req;
    wb_info_t   wb_next;
    rv32i_word  rdata;

    ex_mem_reg ex_mem_reg_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .ex_valid_i   (ex_valid_i),
        .ex_result_i  (ex_result_i),
        .mem_valid_o  (mem_valid),
        .mem_result_o (mem_result)
    );

    mem_stage mem_stage_i (
        .mem_valid_i   (mem_valid),
        .mem_result_i  (mem_result),
        .mem_req_o     (mem_req),
        .wb_next_o     (wb_next),
        .pc_redirect_o (pc_redirect_o),
        .pc_target_o   (pc_target_o)
    );

    data_ram data_ram_i (
        .clk_i     (clk_i),
        .mem_req_i (mem_req),
        .rdata_o   (rdata)
    );

    mem_wb_align mem_wb_align_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .mem_valid_i (mem_valid),
        .wb_next_i   (wb_next),
        .rdata_i     (rdata),
        .wb_valid_o  (wb_valid_o),
        .wb_we_o     (wb_we_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

`default_nettype wire

// File: src/mem_wb_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_align (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        mem_valid_i,
    input  rv32i_types_pkg::wb_info_t   wb_next_i,
    input  rv32i_types_pkg::rv32i_word  rdata_i,
    output logic                        wb_valid_o,
    output logic                        wb_we_o,
    output rv32i_types_pkg::rv32i_reg   wb_rd_o,
    output rv32i_types_pkg::rv32i_word  wb_data_o
);
    import rv32i_types_pkg::*;

    logic      valid_q;
    wb_info_t  wb_q;
    rv32i_word shifted;
    rv32i_word load_val;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q <= wb_next_i;  // lines up with the registered RAM read.
    end

    // Bring the addressed byte or halfword down to lane 0.
    assign shifted = rdata_i >> {wb_q.byte_off, 3'b000};

    always_comb begin
        case (wb_q.funct3)
            f3_byte: begin
                load_val = {{24{shifted[7]}}, shifted[7:0]};
            end
            f3_half: begin
                load_val = {{16{shifted[15]}}, shifted[15:0]};
            end
            f3_byte_u: begin
                load_val = {24'd0, shifted[7:0]};
            end
            f3_half_u: begin
                load_val = {16'd0, shifted[15:0]};
            end
            f3_word: begin
                load_val = shifted;
            end
            default: begin
                load_val = shifted;
            end
        endcase
    end

    always_comb begin
        if (wb_q.mem_read) begin
            wb_data_o = load_val;
        end else if (wb_q.is_jump) begin
            wb_data_o = wb_q.pc_plus4;  // link value for jal and jalr.
        end else begin
            wb_data_o = wb_q.alu_out;
        end
    end

    assign wb_valid_o = valid_q;
    assign wb_rd_o    = wb_q.rd;
    assign wb_we_o    = valid_q & wb_q.load_regfile & (wb_q.rd != 5'd0);  // x0 stays zero.

endmodule

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_mem_cfg.svh"

module data_ram (
    input  logic                        clk_i,
    input  rv32i_types_pkg::mem_req_t   mem_req_i,
    output rv32i_types_pkg::rv32i_word  rdata_o
);
    import rv32i_types_pkg::*;

    localparam int unsigned depth = 1 << `RV32I_DMEM_AW;

    rv32i_word                mem [depth];
    logic [`RV32I_DMEM_AW-1:0] idx;

    assign idx = mem_req_i.word_addr[`RV32I_DMEM_AW+1:2];  // upper address bits alias.

    always_ff @(posedge clk_i) begin
        if (mem_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req_i.byte_en[b]) begin
                    mem[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data holds its value between loads.
    always_ff @(posedge clk_i) begin
        if (mem_req_i.re) begin
            rdata_o <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_mem_cfg.svh"

module mem_stage (
    input  logic                         mem_valid_i,
    input  rv32i_types_pkg::ex_result_t  mem_result_i,
    output rv32i_types_pkg::mem_req_t    mem_req_o,
    output rv32i_types_pkg::wb_info_t    wb_next_o,
    output logic                         pc_redirect_o,
    output rv32i_types_pkg::rv32i_word   pc_target_o
);
    import rv32i_types_pkg::*;

    rv32i_word  addr;
    logic [1:0] byte_off;
    logic       is_branch;
    logic       is_jump;

    always_comb begin
        if (mem_result_i.ctrl.marmux_sel) begin
            addr = mem_result_i.alu_out;
        end else begin
            addr = mem_result_i.pc;
        end
    end

    assign byte_off = addr[1:0];

    assign is_branch = (mem_result_i.ctrl.opcode == op_br);
    assign is_jump   = (mem_result_i.ctrl.opcode == op_jal) ||
                       (mem_result_i.ctrl.opcode == op_jalr);

    always_comb begin
        mem_req_o.word_addr = addr[`RV32I_XLEN-1:2];
        mem_req_o.byte_en   = mem_result_i.ctrl.mem_byte_en << byte_off;
        mem_req_o.wdata     = mem_result_i.rs2_out << {byte_off, 3'b000};  // lane align.
        mem_req_o.we        = mem_valid_i & mem_result_i.ctrl.mem_write;
        mem_req_o.re        = mem_valid_i & mem_result_i.ctrl.mem_read;
    end

    // Taken branches only; jumps are resolved earlier in the pipeline.
    assign pc_redirect_o = mem_valid_i & is_branch & mem_result_i.br_en;
    assign pc_target_o   = mem_result_i.alu_out;

    always_comb begin
        wb_next_o.rd           = mem_result_i.rd;
        wb_next_o.load_regfile = mem_valid_i & mem_result_i.ctrl.load_regfile;
        wb_next_o.mem_read     = mem_result_i.ctrl.mem_read;
        wb_next_o.is_jump      = is_jump;
        wb_next_o.funct3       = mem_result_i.ctrl.funct3;
        wb_next_o.byte_off     = byte_off;  // needed again to pull the load out of the word.
        wb_next_o.alu_out      = mem_result_i.alu_out;
        wb_next_o.pc_plus4     = mem_result_i.pc_plus4;
    end

endmodule

`default_nettype wire

// File: src/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         ex_valid_i,
    input  rv32i_types_pkg::ex_result_t  ex_result_i,
    output logic                         mem_valid_o,
    output rv32i_types_pkg::ex_result_t  mem_result_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o <= 1'b0;
        end else begin
            mem_valid_o <= ex_valid_i;  // bubbles pass through as valid low.
        end
    end

    // The payload is qualified by mem_valid_o downstream.
    always_ff @(posedge clk_i) begin
        mem_result_o <= ex_result_i;
    end

endmodule

`default_nettype wire

// File: src/rv32i_types_pkg.sv
`default_nettype none

`include "rv32i_mem_cfg.svh"

package rv32i_types_pkg;

    typedef logic [`RV32I_XLEN-1:0] rv32i_word;
    typedef logic [4:0]             rv32i_reg;
    typedef logic [6:0]             rv32i_opcode;
    typedef logic [2:0]             rv32i_funct3;
    typedef logic [3:0]             rv32i_ben;

    localparam rv32i_opcode op_br    = 7'b1100011;
    localparam rv32i_opcode op_load  = 7'b0000011;
    localparam rv32i_opcode op_store = 7'b0100011;
    localparam rv32i_opcode op_jal   = 7'b1101111;
    localparam rv32i_opcode op_jalr  = 7'b1100111;
    localparam rv32i_opcode op_imm   = 7'b0010011;
    localparam rv32i_opcode op_reg   = 7'b0110011;

    // Stores share the low three codes with the loads.
    localparam rv32i_funct3 f3_byte   = 3'b000;
    localparam rv32i_funct3 f3_half   = 3'b001;
    localparam rv32i_funct3 f3_word   = 3'b010;
    localparam rv32i_funct3 f3_byte_u = 3'b100;
    localparam rv32i_funct3 f3_half_u = 3'b101;

    typedef struct packed {
        rv32i_opcode opcode;
        rv32i_funct3 funct3;
        logic        load_regfile;
        logic        mem_read;
        logic        mem_write;
        rv32i_ben    mem_byte_en;  // unshifted mask, lane 0 based.
        logic        marmux_sel;   // 1 picks alu_out as address.
    } rv32i_ctrl_t;

    typedef struct packed {
        rv32i_word   pc;
        rv32i_word   pc_plus4;
        rv32i_word   alu_out;
        rv32i_word   rs2_out;
        logic        br_en;
        rv32i_reg    rd;
        rv32i_ctrl_t ctrl;
    } ex_result_t;

    typedef struct packed {
        logic [`RV32I_XLEN-1:2] word_addr;
        rv32i_word              wdata;  // already placed in its byte lanes.
        rv32i_ben               byte_en;
        logic                   we;
        logic                   re;
    } mem_req_t;

    typedef struct packed {
        rv32i_reg    rd;
        logic        load_regfile;
        logic        mem_read;
        logic        is_jump;
        rv32i_funct3 funct3;
        logic [1:0]  byte_off;
        rv32i_word   alu_out;
        rv32i_word   pc_plus4;
    } wb_info_t;

endpackage

`default_nettype wire

// File: include/rv32i_mem_cfg.svh
`ifndef RV32I_MEM_CFG_SVH
`define RV32I_MEM_CFG_SVH

// Data and address width of the integer pipeline.
`define RV32I_XLEN 32

// log2 of the data RAM depth in 32-bit words.
`define RV32I_DMEM_AW 8

`endif
